// ==== include/inst_defs.svh ====
`ifndef INST_DEFS_SVH
`define INST_DEFS_SVH

// major opcode and fixed register fields
`define OP_FIELD          6:0
`define REG_RD            11:7
`define FUNCT_3_FIELD     14:12
`define REG_RS1           19:15
`define REG_RS2           24:20
`define FUNCT_7_FIELD     31:25

// sign bit shared by every immediate format
`define INST_SIGN         31

// I-type
`define IMM_FIELD_I       31:20

// S-type, upper and lower halves
`define IMM_FIELD_S_U     31:25
`define IMM_FIELD_S_L     11:7

// B-type pieces, bit 0 of the offset is implied
`define IMM_FIELD_B_12    31
`define IMM_FIELD_B_11    7
`define IMM_FIELD_B_10_5  30:25
`define IMM_FIELD_B_4_1   11:8

// U-type
`define IMM_FIELD_U       31:12

// J-type pieces
`define IMM_FIELD_J_20    31
`define IMM_FIELD_J_19_12 19:12
`define IMM_FIELD_J_11    20
`define IMM_FIELD_J_10_1  30:21

// opcode values
`define OP_R3             7'b0110011
`define OP_IMM            7'b0010011
`define OP_LUI            7'b0110111
`define OP_AUIPC          7'b0010111
`define OP_JAL            7'b1101111
`define OP_JALR           7'b1100111
`define OP_BR             7'b1100011
`define OP_LD             7'b0000011
`define OP_ST             7'b0100011
`define OP_SYS            7'b1110011    // ecall / ebreak

`endif

// ==== source/riscv_pkg.sv ====
`default_nettype none

package riscv_pkg;

    typedef logic [31:0] word_t;        // data, address or instruction
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [6:0]  opcode_t;

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    localparam int IMEM_AW = $clog2(IMEM_WORDS);  // word index widths
    localparam int DMEM_AW = $clog2(DMEM_WORDS);
    localparam word_t RESET_PC = 32'h0000_0000;

    // funct3 for OP and OP-IMM
    localparam funct3_t F3_ADD_SUB = 3'd0;
    localparam funct3_t F3_SLL     = 3'd1;
    localparam funct3_t F3_SLT     = 3'd2;
    localparam funct3_t F3_SLTU    = 3'd3;
    localparam funct3_t F3_XOR     = 3'd4;
    localparam funct3_t F3_SRL_SRA = 3'd5;
    localparam funct3_t F3_OR      = 3'd6;
    localparam funct3_t F3_AND     = 3'd7;

    // branch conditions
    localparam funct3_t F3_BEQ  = 3'd0;
    localparam funct3_t F3_BNE  = 3'd1;
    localparam funct3_t F3_BLT  = 3'd4;
    localparam funct3_t F3_BGE  = 3'd5;
    localparam funct3_t F3_BLTU = 3'd6;
    localparam funct3_t F3_BGEU = 3'd7;

    // load / store sizes
    localparam funct3_t F3_B  = 3'd0;
    localparam funct3_t F3_H  = 3'd1;
    localparam funct3_t F3_W  = 3'd2;
    localparam funct3_t F3_BU = 3'd4;
    localparam funct3_t F3_HU = 3'd5;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {ST_LOAD, ST_RUN, ST_HALTED} core_state_t;

endpackage

`default_nettype wire

// ==== source/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "inst_defs.svh"

module inst_decoder
    import riscv_pkg::*;
(
    input  word_t     inst,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output opcode_t   op,
    output funct3_t   funct3,
    output funct7_t   funct7,
    output word_t     imm
);

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign op = inst[`OP_FIELD];

    // immediates for every format, the case below picks one
    assign imm_i = {{20{inst[`INST_SIGN]}}, inst[`IMM_FIELD_I]};
    assign imm_s = {{20{inst[`INST_SIGN]}}, inst[`IMM_FIELD_S_U], inst[`IMM_FIELD_S_L]};
    assign imm_u = {inst[`IMM_FIELD_U], 12'b0};   // field shifted up by 12

    assign imm_b = {{19{inst[`INST_SIGN]}},
                    inst[`IMM_FIELD_B_12],
                    inst[`IMM_FIELD_B_11],
                    inst[`IMM_FIELD_B_10_5],
                    inst[`IMM_FIELD_B_4_1],
                    1'b0};                        // offsets are always even

    assign imm_j = {{11{inst[`INST_SIGN]}},
                    inst[`IMM_FIELD_J_20],
                    inst[`IMM_FIELD_J_19_12],
                    inst[`IMM_FIELD_J_11],
                    inst[`IMM_FIELD_J_10_1],
                    1'b0};

    always_comb begin
        // unused fields stay zero
        rs1    = '0;
        rs2    = '0;
        rd     = '0;
        funct3 = '0;
        funct7 = '0;
        imm    = '0;
        case (op)
            `OP_R3: begin
                rd     = inst[`REG_RD];
                rs1    = inst[`REG_RS1];
                rs2    = inst[`REG_RS2];
                funct3 = inst[`FUNCT_3_FIELD];
                funct7 = inst[`FUNCT_7_FIELD];
            end
            `OP_IMM: begin
                rd     = inst[`REG_RD];
                rs1    = inst[`REG_RS1];
                funct3 = inst[`FUNCT_3_FIELD];
                funct7 = inst[`FUNCT_7_FIELD];   // srai/srli selector
                imm    = imm_i;
            end
            `OP_LUI, `OP_AUIPC: begin           // U-type
                rd  = inst[`REG_RD];
                imm = imm_u;
            end
            `OP_JAL: begin                      // J-type
                rd  = inst[`REG_RD];
                imm = imm_j;
            end
            `OP_JALR, `OP_LD: begin             // I-type with base register
                rd     = inst[`REG_RD];
                rs1    = inst[`REG_RS1];
                funct3 = inst[`FUNCT_3_FIELD];
                imm    = imm_i;
            end
            `OP_BR: begin                       // B-type
                rs1    = inst[`REG_RS1];
                rs2    = inst[`REG_RS2];
                funct3 = inst[`FUNCT_3_FIELD];
                imm    = imm_b;
            end
            `OP_ST: begin                       // S-type
                rs1    = inst[`REG_RS1];
                rs2    = inst[`REG_RS2];
                funct3 = inst[`FUNCT_3_FIELD];
                imm    = imm_s;
            end
            default: begin
                imm = '0;   // system and unknown opcodes carry no fields
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import riscv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      we,
    input  reg_addr_t rd,
    input  word_t     rd_data
);

    word_t regs [1:31];     // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    // combinational reads, x0 forced to zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
    import riscv_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t alu_op,
    output word_t   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];   // only the low five bits shift

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SLT: begin
                result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            ALU_SLTU: begin
                result = (a < b) ? 32'd1 : 32'd0;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_SRA: begin
                result = word_t'($signed(a) >>> shamt);  // keeps the sign
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_PASS_B: begin
                result = b;         // lui
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem
    import riscv_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  word_t   addr,
    input  funct3_t funct3,
    input  logic    store,
    input  word_t   store_data,
    output word_t   load_data
);

    word_t              mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] index;
    word_t              word_rd;
    logic [3:0]         lane_en;
    word_t              lane_data;
    logic [7:0]         byte_sel;
    logic [15:0]        half_sel;

    assign index   = addr[DMEM_AW+1:2];   // wraps modulo the depth
    assign word_rd = mem[index];

    // byte lanes from size and low address bits
    always_comb begin
        case (funct3)
            F3_B: begin
                lane_en   = 4'b0001 << addr[1:0];
                lane_data = {4{store_data[7:0]}};
            end
            F3_H: begin
                lane_en   = addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{store_data[15:0]}};
            end
            default: begin
                lane_en   = 4'b1111;
                lane_data = store_data;
            end
        endcase
    end

    // no writes while reset is held
    always_ff @(posedge clk) begin
        if (store && rst_n) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_en[i])
                    mem[index][8*i +: 8] <= lane_data[8*i +: 8];
            end
        end
    end

    assign byte_sel = word_rd[{addr[1:0], 3'b000} +: 8];
    assign half_sel = addr[1] ? word_rd[31:16] : word_rd[15:0];

    always_comb begin
        case (funct3)
            F3_B:    load_data = {{24{byte_sel[7]}}, byte_sel};
            F3_BU:   load_data = {24'b0, byte_sel};
            F3_H:    load_data = {{16{half_sel[15]}}, half_sel};
            F3_HU:   load_data = {16'b0, half_sel};
            F3_W:    load_data = word_rd;
            default: load_data = word_rd;   // undefined sizes read the word
        endcase
    end

endmodule

`default_nettype wire

// ==== source/rv32_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "inst_defs.svh"

module rv32_core
    import riscv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      run,
    input  logic      imem_we,
    input  word_t     imem_addr,
    input  word_t     imem_wdata,
    output logic      retire_valid,
    output word_t     retire_pc,
    output logic      retire_rd_we,
    output reg_addr_t retire_rd,
    output word_t     retire_rd_wdata,
    output logic      halted,
    output word_t     halt_pc
);

    core_state_t state;
    word_t       pc;
    word_t       imem [IMEM_WORDS];
    word_t       inst;
    reg_addr_t   rs1, rs2, rd;
    opcode_t     op;
    funct3_t     funct3;
    funct7_t     funct7;
    word_t       imm;
    word_t       rs1_data, rs2_data;
    word_t       alu_a, alu_b, alu_result;
    alu_op_t     alu_op;
    word_t       load_data;
    word_t       pc_plus4, next_pc, wb_data;
    logic        exec, legal, rd_we, br_taken, halt_now;

    // program load only while not running
    always_ff @(posedge clk) begin
        if (imem_we && state != ST_RUN)
            imem[imem_addr[IMEM_AW+1:2]] <= imem_wdata;
    end

    assign inst     = imem[pc[IMEM_AW+1:2]];
    assign exec     = (state == ST_RUN);
    assign pc_plus4 = pc + 32'd4;

    inst_decoder u_dec (.inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .op(op),
                        .funct3(funct3), .funct7(funct7), .imm(imm));

    reg_file u_rf (.clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2),
                   .rs1_data(rs1_data), .rs2_data(rs2_data),
                   .we(exec && rd_we), .rd(rd), .rd_data(wb_data));

    assign alu_a = (op == `OP_AUIPC) ? pc : rs1_data;
    assign alu_b = (op == `OP_R3) ? rs2_data : imm;

    always_comb begin
        alu_op = ALU_ADD;    // also address calc for loads, stores, jalr
        if (op == `OP_R3 || op == `OP_IMM) begin
            case (funct3)
                F3_ADD_SUB: alu_op = (op == `OP_R3 && funct7[5]) ? ALU_SUB : ALU_ADD;
                F3_SLL:     alu_op = ALU_SLL;
                F3_SLT:     alu_op = ALU_SLT;
                F3_SLTU:    alu_op = ALU_SLTU;
                F3_XOR:     alu_op = ALU_XOR;
                F3_SRL_SRA: alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                F3_OR:      alu_op = ALU_OR;
                F3_AND:     alu_op = ALU_AND;
                default:    alu_op = ALU_ADD;
            endcase
        end else if (op == `OP_LUI) begin
            alu_op = ALU_PASS_B;
        end
    end

    alu u_alu (.a(alu_a), .b(alu_b), .alu_op(alu_op), .result(alu_result));

    data_mem u_dmem (.clk(clk), .rst_n(rst_n), .addr(alu_result), .funct3(funct3),
                     .store(exec && op == `OP_ST), .store_data(rs2_data),
                     .load_data(load_data));

    // branch compare, independent of the alu
    always_comb begin
        case (funct3)
            F3_BEQ:  br_taken = (rs1_data == rs2_data);
            F3_BNE:  br_taken = (rs1_data != rs2_data);
            F3_BLT:  br_taken = ($signed(rs1_data) < $signed(rs2_data));
            F3_BGE:  br_taken = ($signed(rs1_data) >= $signed(rs2_data));
            F3_BLTU: br_taken = (rs1_data < rs2_data);
            F3_BGEU: br_taken = (rs1_data >= rs2_data);
            default: br_taken = 1'b0;
        endcase
    end

    // writeback select and next pc
    always_comb begin
        legal   = 1'b1;
        rd_we   = 1'b0;
        wb_data = alu_result;
        next_pc = pc_plus4;
        case (op)
            `OP_R3, `OP_IMM, `OP_LUI, `OP_AUIPC: begin
                rd_we = 1'b1;
            end
            `OP_JAL: begin
                rd_we   = 1'b1;
                wb_data = pc_plus4;     // link
                next_pc = pc + imm;
            end
            `OP_JALR: begin
                rd_we   = 1'b1;
                wb_data = pc_plus4;
                next_pc = {alu_result[31:1], 1'b0};
            end
            `OP_BR: begin
                if (br_taken)
                    next_pc = pc + imm;
            end
            `OP_LD: begin
                rd_we   = 1'b1;
                wb_data = load_data;
            end
            `OP_ST: begin
                rd_we = 1'b0;           // memory side effect only
            end
            default: begin
                legal = 1'b0;           // ecall, ebreak, fence, unknown
            end
        endcase
    end

    assign halt_now = exec && !legal;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_LOAD;
            pc      <= RESET_PC;
            halt_pc <= RESET_PC;
        end else begin
            case (state)
                ST_LOAD: begin
                    if (run)
                        state <= ST_RUN;
                end
                ST_RUN: begin
                    if (halt_now) begin
                        state   <= ST_HALTED;
                        halt_pc <= pc;
                    end else begin
                        pc <= next_pc;
                    end
                end
                default: state <= ST_HALTED;    // stays stopped
            endcase
        end
    end

    assign retire_valid    = exec;
    assign retire_pc       = pc;
    assign retire_rd_we    = exec && rd_we;
    assign retire_rd       = rd;
    assign retire_rd_wdata = wb_data;
    assign halted          = (state == ST_HALTED);

endmodule

`default_nettype wire

// ==== tb/tb_rv32_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv32_core
    import riscv_pkg::*;
();

    localparam int    RETIRE_TIMEOUT = 40;      // cycles allowed per retire
    localparam int    HALT_TIMEOUT   = 10;
    localparam int    QUIET_CYCLES   = 20;      // window after halt
    localparam string DATA_FILE      = "tb/core_testdata.txt";

    logic      clk;
    logic      rst_n;
    logic      run;
    logic      imem_we;
    word_t     imem_addr;
    word_t     imem_wdata;
    logic      retire_valid;
    word_t     retire_pc;
    logic      retire_rd_we;
    reg_addr_t retire_rd;
    word_t     retire_rd_wdata;
    logic      halted;
    word_t     halt_pc;

    // program image and expected retire stream from the data file
    word_t     prog_addr [$];
    word_t     prog_word [$];
    word_t     exp_pc [$];
    logic      exp_we [$];
    reg_addr_t exp_rd [$];
    word_t     exp_wdata [$];
    word_t     exp_halt_pc;
    logic      have_halt;

    rv32_core uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .run             (run),
        .imem_we         (imem_we),
        .imem_addr       (imem_addr),
        .imem_wdata      (imem_wdata),
        .retire_valid    (retire_valid),
        .retire_pc       (retire_pc),
        .retire_rd_we    (retire_rd_we),
        .retire_rd       (retire_rd),
        .retire_rd_wdata (retire_rd_wdata),
        .halted          (halted),
        .halt_pc         (halt_pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("** Error: time %0t, %s = 0x%h, expected 0x%h",
                     $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic read_testdata();
        int                fd;
        int                n;
        logic [7:0]        kind;
        logic [8*160-1:0]  rest;
        word_t             f0, f1, f2, f3;
        have_halt = 1'b0;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("could not open the data file %s", DATA_FILE);
            stop_with_failure();
        end
        n = $fscanf(fd, " %c", kind);
        while (n == 1) begin
            if (kind == "#") begin
                n = $fgets(rest, fd);           // comment, drop the line
            end else if (kind == "I") begin
                n = $fscanf(fd, "%h %h", f0, f1);
                prog_addr.push_back(f0);
                prog_word.push_back(f1);
            end else if (kind == "R") begin
                n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                exp_pc.push_back(f0);
                exp_we.push_back(f1[0]);
                exp_rd.push_back(f2[4:0]);
                exp_wdata.push_back(f3);
            end else if (kind == "H") begin
                n = $fscanf(fd, "%h", f0);
                exp_halt_pc = f0;
                have_halt   = 1'b1;
            end else begin
                $display("unknown record kind '%c' in %s", kind, DATA_FILE);
                stop_with_failure();
            end
            n = $fscanf(fd, " %c", kind);
        end
        $fclose(fd);
        if (prog_addr.size() == 0 || exp_pc.size() == 0 || !have_halt) begin
            $display("data file %s lacks program, retire or halt records", DATA_FILE);
            stop_with_failure();
        end
    endtask

    // one word per cycle through the imem port, then run goes high
    task automatic load_program();
        for (int i = 0; i < prog_addr.size(); i++) begin
            @(posedge clk);
            #1;
            imem_we    = 1'b1;
            imem_addr  = prog_addr[i];
            imem_wdata = prog_word[i];
        end
        @(posedge clk);
        #1;
        imem_we = 1'b0;
        run     = 1'b1;
    endtask

    // moves to the next mid-cycle point that carries a retire
    task automatic wait_retire(input int index);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!retire_valid && cycles < RETIRE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!retire_valid) begin
            $display("timed out after %0d cycles waiting for retire number %0d",
                     RETIRE_TIMEOUT, index);
            stop_with_failure();
        end
    endtask

    task automatic wait_halt();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!halted && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("timed out after %0d cycles waiting for the core to halt", HALT_TIMEOUT);
            stop_with_failure();
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        read_testdata();

        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("retire_valid", word_t'(retire_valid), 32'd0);   // quiet in reset
        check_value("retire_rd_we", word_t'(retire_rd_we), 32'd0);
        check_value("halted", word_t'(halted), 32'd0);
        @(posedge clk);
        #1;
        rst_n = 1'b1;

        load_program();

        for (int i = 0; i < exp_pc.size(); i++) begin
            wait_retire(i);
            check_value("retire_pc", retire_pc, exp_pc[i]);
            check_value("retire_rd_we", word_t'(retire_rd_we), word_t'(exp_we[i]));
            if (exp_we[i]) begin
                check_value("retire_rd", word_t'(retire_rd), word_t'(exp_rd[i]));
                check_value("retire_rd_wdata", retire_rd_wdata, exp_wdata[i]);
            end
            check_value("halted", word_t'(halted), 32'd0);
        end

        wait_halt();
        check_value("halt_pc", halt_pc, exp_halt_pc);
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            check_value("retire_valid", word_t'(retire_valid), 32'd0);
            check_value("halted", word_t'(halted), 32'd1);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
source/riscv_pkg.sv
source/inst_decoder.sv
source/reg_file.sv
source/alu.sv
source/data_mem.sv
source/rv32_core.sv
tb/tb_rv32_core.sv

// ==== Makefile ====
# Verilator build and run for the rv32 core testbench

TOP       ?= tb_rv32_core
RTL_TOP   ?= rv32_core
VERILATOR ?= verilator
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard source/*.sv include/*.svh tb/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || (echo "run ended early, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/core_testdata.txt ====
# I addr word | R pc rd_we rd wdata, rd and wdata matter only when rd_we is 1
# H halt_pc, every field in hex
I 00 123450B7
I 04 00001117
I 08 FFB00193
I 0C 00700213
I 10 403202B3
I 14 4011D313
I 18 0011D393
I 1C 0041D433
I 20 0041A4B3
I 24 0041B533
I 28 0042E5B3
I 2C FFF5C613
I 30 00421693
I 34 0FF67713
I 38 00520013
I 3C 004007B3
I 40 04000813
I 44 FE182E23
I 48 FFC82883
I 4C 00382023
I 50 00E800A3
I 54 00B81123
I 58 00080903
I 5C 00084983
I 60 00081A03
I 64 00085A83
I 68 00082B03
I 6C 00180B83
I 70 00F20463
I 74 00100C13
I 78 00F21463
I 7C 0041C463
I 80 00100C13
I 84 0041E463
I 88 0041D463
I 8C 0041F463
I 90 00100C13
I 94 00C00CEF
I 98 00DC8DE7
I 9C 00100C13
I A0 FF9FFD6F
I A4 00200E13
I A8 FFFE0E13
I AC FE0E1EE3
I B0 00100073
# lui, auipc, negative addi
R 00 1 01 12345000
R 04 1 02 00001004
R 08 1 03 FFFFFFFB
R 0C 1 04 00000007
# sub, srai vs srli, srl, slt vs sltu, or, xori, slli, andi
R 10 1 05 0000000C
R 14 1 06 FFFFFFFD
R 18 1 07 7FFFFFFD
R 1C 1 08 01FFFFFF
R 20 1 09 00000001
R 24 1 0A 00000000
R 28 1 0B 0000000F
R 2C 1 0C FFFFFFF0
R 30 1 0D 00000070
R 34 1 0E 000000F0
# write to x0 is reported, later read of x0 gives zero
R 38 1 00 0000000C
R 3C 1 0F 00000007
# base, sw/lw with negative offset, sized stores and loads
R 40 1 10 00000040
R 44 0 00 00000000
R 48 1 11 12345000
R 4C 0 00 00000000
R 50 0 00 00000000
R 54 0 00 00000000
R 58 1 12 FFFFFFFB
R 5C 1 13 000000FB
R 60 1 14 FFFFF0FB
R 64 1 15 0000F0FB
R 68 1 16 000FF0FB
R 6C 1 17 FFFFFFF0
# beq taken, bne not, blt taken, bltu not, bge not, bgeu taken
R 70 0 00 00000000
R 78 0 00 00000000
R 7C 0 00 00000000
R 84 0 00 00000000
R 88 0 00 00000000
R 8C 0 00 00000000
# jal forward, jal backward, jalr with bit 0 cleared
R 94 1 19 00000098
R A0 1 1A 000000A4
R 98 1 1B 0000009C
# countdown loop with a backward bne
R A4 1 1C 00000002
R A8 1 1C 00000001
R AC 0 00 00000000
R A8 1 1C 00000000
R AC 0 00 00000000
# ebreak
R B0 0 00 00000000
H B0
